//--- verilog/rob_pkg.sv
/* reorder buffer shared definitions
   entry widths, vector types and the retire state encoding */
`default_nettype none

package rob_pkg;

    //////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////

    // default entry count, power of two
    localparam int ROB_DEPTH = 8;
    // log2 of the default entry count
    localparam int LOG_ROB_DEPTH = 3;

    // physical register tag width
    localparam int PHYS_TAG_W = 6;

    // completion buses for alu 0, alu 1 and the load queue
    localparam int NUM_COMPLETE = 3;

    //////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////

    // slot number inside the buffer
    typedef logic [LOG_ROB_DEPTH-1:0] rob_index_t;

    // index with wrap bit on top
    // also wide enough to count a full buffer
    typedef logic [LOG_ROB_DEPTH:0] rob_ptr_t;

    // renamed destination register
    typedef logic [PHYS_TAG_W-1:0] phys_tag_t;

    //////////////////////////////////////////////////
    // retire control states
    //////////////////////////////////////////////////

    // halt is terminal, only reset leaves it
    typedef enum logic [0:0] {
        IDLE = 1'b0,
        HALT = 1'b1
    } rob_state_t;

endpackage

`default_nettype wire

//--- verilog/rob_head_if.sv
/* head entry view between entry storage and retire control */
`timescale 1ns/1ns
`default_nettype none

interface rob_head_if;

    // oldest entry, read straight from storage
    logic                head_valid;
    logic                head_complete;
    logic                head_reg_write;
    logic                head_halt;
    rob_pkg::phys_tag_t  head_safe_tag;

    // head leaves this cycle
    // only while valid, complete and not halted
    logic                head_retire;

    // storage side presents the head entry
    modport store (
        output head_valid,
        output head_complete,
        output head_reg_write,
        output head_halt,
        output head_safe_tag,
        input  head_retire
    );

    // retire side decides and strobes
    modport retire (
        input  head_valid,
        input  head_complete,
        input  head_reg_write,
        input  head_halt,
        input  head_safe_tag,
        output head_retire
    );

endinterface

`default_nettype wire

//--- verilog/rob_ptr_ctrl.sv
/* reorder buffer head and tail pointers
   accepts enqueues, tracks occupancy, full, empty and overflow */
`timescale 1ns/1ns
`default_nettype none

module rob_ptr_ctrl #(
    parameter int DEPTH = 8
) (
    input  logic                CLK,
    input  logic                nRST,

    // dispatch request and head departure
    input  logic                enqueue,
    input  logic                retire,

    // accepted enqueue
    output logic                alloc,

    output rob_pkg::rob_index_t head_index,
    output rob_pkg::rob_index_t tail_index,
    output rob_pkg::rob_ptr_t   occupancy,
    output logic                full,
    output logic                empty,
    output logic                overflow_error
);

    // index bits for this depth
    localparam int IDX_W = $clog2(DEPTH);

    // pointers carry a wrap bit above the index
    logic [IDX_W:0] head_ptr;
    logic [IDX_W:0] tail_ptr;
    logic [IDX_W:0] next_head_ptr;
    logic [IDX_W:0] next_tail_ptr;

    //////////////////////////////////////////////////
    // next pointers
    //////////////////////////////////////////////////

    // enqueue while full is refused, not stalled
    assign alloc = enqueue & ~full;

    assign next_tail_ptr = alloc  ? tail_ptr + (IDX_W+1)'(1) : tail_ptr;
    assign next_head_ptr = retire ? head_ptr + (IDX_W+1)'(1) : head_ptr;

    // slot numbers drop the wrap bit
    assign head_index = rob_pkg::rob_index_t'(head_ptr[IDX_W-1:0]);
    assign tail_index = rob_pkg::rob_index_t'(tail_ptr[IDX_W-1:0]);

    //////////////////////////////////////////////////
    // registered status
    //////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            head_ptr       <= '0;
            tail_ptr       <= '0;
            occupancy      <= '0;
            full           <= 1'b0;
            // starts empty
            empty          <= 1'b1;
            overflow_error <= 1'b0;
        end else begin
            head_ptr  <= next_head_ptr;
            tail_ptr  <= next_tail_ptr;
            occupancy <= rob_pkg::rob_ptr_t'(next_tail_ptr - next_head_ptr);
            // same slot, wrap bits differ
            full      <= (next_head_ptr[IDX_W-1:0] == next_tail_ptr[IDX_W-1:0]) &&
                         (next_head_ptr[IDX_W] != next_tail_ptr[IDX_W]);
            // same slot, same lap
            empty     <= (next_head_ptr == next_tail_ptr);
            // dropped enqueue, one cycle later
            overflow_error <= enqueue & full;
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // retire control must never pull from an empty buffer
    a_no_retire_empty: assert property (
        @(posedge CLK) disable iff (!nRST) retire |-> !empty
    );

    // both flags track the same pointers over time
    a_full_empty_excl: assert property (
        @(posedge CLK) disable iff (!nRST) !(full && empty)
    );

endmodule

`default_nettype wire

//--- verilog/rob_entry_array.sv
/* reorder buffer entry storage
   writes at tail, marks completions, checks tags, shows the head entry */
`timescale 1ns/1ns
`default_nettype none

module rob_entry_array #(
    parameter int DEPTH = 8
) (
    input  logic                CLK,
    input  logic                nRST,

    // dispatch write at tail
    input  logic                alloc,
    input  rob_pkg::rob_index_t tail_index,
    input  rob_pkg::rob_index_t head_index,
    input  logic                enq_reg_write,
    input  logic                enq_halt,
    input  rob_pkg::phys_tag_t  enq_spec_tag,
    input  rob_pkg::phys_tag_t  enq_safe_tag,

    // completion buses
    input  logic                [rob_pkg::NUM_COMPLETE-1:0] comp_valid,
    input  rob_pkg::rob_index_t [rob_pkg::NUM_COMPLETE-1:0] comp_index,
    input  rob_pkg::phys_tag_t  [rob_pkg::NUM_COMPLETE-1:0] comp_tag,

    rob_head_if.store           head,

    output logic                invalid_complete,
    output logic                tag_error
);

    //////////////////////////////////////////////////
    // entry state
    //////////////////////////////////////////////////

    // control bits
    logic [DEPTH-1:0] entry_valid;
    logic [DEPTH-1:0] entry_complete;

    // payload, written on alloc only
    logic [DEPTH-1:0] entry_reg_write;
    logic [DEPTH-1:0] entry_halt;
    rob_pkg::phys_tag_t entry_spec_tag [DEPTH];
    rob_pkg::phys_tag_t entry_safe_tag [DEPTH];

    // per bus lookup
    logic [rob_pkg::NUM_COMPLETE-1:0] comp_new;
    logic [rob_pkg::NUM_COMPLETE-1:0] comp_live;
    rob_pkg::phys_tag_t [rob_pkg::NUM_COMPLETE-1:0] comp_stored_tag;

    logic next_tag_error;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            entry_valid    <= '0;
            entry_complete <= '0;
        end else begin
            // head leaves
            if (head.head_retire) begin
                entry_valid[head_index] <= 1'b0;
            end
            // new entry, not yet complete
            if (alloc) begin
                entry_valid[tail_index]    <= 1'b1;
                entry_complete[tail_index] <= 1'b0;
            end
            // completions last, so a same cycle alloc still completes
            for (int i = 0; i < rob_pkg::NUM_COMPLETE; i++) begin
                if (comp_valid[i]) begin
                    entry_complete[comp_index[i]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (alloc) begin
            entry_reg_write[tail_index] <= enq_reg_write;
            entry_halt[tail_index]      <= enq_halt;
            entry_spec_tag[tail_index]  <= enq_spec_tag;
            entry_safe_tag[tail_index]  <= enq_safe_tag;
        end
    end

    //////////////////////////////////////////////////
    // completion checks
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < rob_pkg::NUM_COMPLETE; i++) begin
            // bus hits the slot being written now
            comp_new[i]        = alloc && (comp_index[i] == tail_index);
            comp_live[i]       = entry_valid[comp_index[i]] | comp_new[i];
            comp_stored_tag[i] = comp_new[i] ? enq_spec_tag : entry_spec_tag[comp_index[i]];
        end
    end

    always_comb begin
        invalid_complete = 1'b0;
        next_tag_error   = 1'b0;
        for (int i = 0; i < rob_pkg::NUM_COMPLETE; i++) begin
            if (comp_valid[i]) begin
                // legal, e.g. a squashed op finishing late
                if (!comp_live[i]) begin
                    invalid_complete = 1'b1;
                end else if (comp_stored_tag[i] != comp_tag[i]) begin
                    next_tag_error = 1'b1;
                end
            end
        end
    end

    // mismatch strobe one cycle later
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            tag_error <= 1'b0;
        end else begin
            tag_error <= next_tag_error;
        end
    end

    //////////////////////////////////////////////////
    // head view
    //////////////////////////////////////////////////

    assign head.head_valid     = entry_valid[head_index];
    assign head.head_complete  = entry_complete[head_index];
    assign head.head_reg_write = entry_reg_write[head_index];
    assign head.head_halt      = entry_halt[head_index];
    assign head.head_safe_tag  = entry_safe_tag[head_index];

    // pointer block's full flag must keep the tail off live entries
    a_alloc_free_slot: assert property (
        @(posedge CLK) disable iff (!nRST) alloc |-> !entry_valid[tail_index]
    );

endmodule

`default_nettype wire

//--- verilog/rob_retire.sv
/* reorder buffer retire control
   in-order retire from the head, idle/halt state machine */
`timescale 1ns/1ns
`default_nettype none

module rob_retire (
    input  logic               CLK,
    input  logic               nRST,

    rob_head_if.retire         head,

    // freed tag back to rename
    output logic               retire_valid,
    output rob_pkg::phys_tag_t retire_tag,

    output logic               halt
);

    rob_pkg::rob_state_t state;
    rob_pkg::rob_state_t next_state;

    //////////////////////////////////////////////////
    // retire decision
    //////////////////////////////////////////////////

    // one per cycle, only from idle
    assign head.head_retire = (state == rob_pkg::IDLE) &&
                              head.head_valid && head.head_complete;

    // only register writers free a tag
    assign retire_valid = head.head_retire & head.head_reg_write;
    assign retire_tag   = head.head_safe_tag;

    assign halt = (state == rob_pkg::HALT);

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            rob_pkg::IDLE: begin
                // halt op leaves the head
                if (head.head_retire && head.head_halt) begin
                    next_state = rob_pkg::HALT;
                end
            end
            rob_pkg::HALT: begin
                // stays until reset
                next_state = rob_pkg::HALT;
            end
            default: begin
                next_state = rob_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= rob_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // after a halt retires, nothing behind it leaves
    a_halt_stops_retire: assert property (
        @(posedge CLK) disable iff (!nRST)
        (head.head_retire && head.head_halt) |=> (halt && !head.head_retire)
    );

endmodule

`default_nettype wire

//--- verilog/rob_top.sv
/* reorder buffer top level
   pointers, entry storage and retire control with plain ports */
`timescale 1ns/1ns
`default_nettype none

module rob_top #(
    parameter int DEPTH = rob_pkg::ROB_DEPTH
) (
    input  logic                CLK,
    input  logic                nRST,

    //////////////////////////////////////////////////
    // dispatch
    //////////////////////////////////////////////////

    input  logic                enq_valid,
    input  logic                enq_reg_write,
    input  logic                enq_halt,
    input  rob_pkg::phys_tag_t  enq_spec_tag,
    input  rob_pkg::phys_tag_t  enq_safe_tag,
    // slot the next dispatch lands in
    output rob_pkg::rob_index_t tail_index,

    //////////////////////////////////////////////////
    // completion buses
    //////////////////////////////////////////////////

    input  logic                [rob_pkg::NUM_COMPLETE-1:0] comp_valid,
    input  rob_pkg::rob_index_t [rob_pkg::NUM_COMPLETE-1:0] comp_index,
    input  rob_pkg::phys_tag_t  [rob_pkg::NUM_COMPLETE-1:0] comp_tag,

    //////////////////////////////////////////////////
    // retire and status
    //////////////////////////////////////////////////

    output logic                retire_valid,
    output rob_pkg::phys_tag_t  retire_tag,
    output logic                halt,
    output logic                full,
    output logic                empty,
    output rob_pkg::rob_ptr_t   occupancy,
    output logic                invalid_complete,
    output logic                error
);

    // accepted enqueue
    logic                alloc;
    rob_pkg::rob_index_t head_index;

    // per block error strobes
    logic                overflow_error;
    logic                tag_error;

    // head entry and retire strobe
    rob_head_if head_bus ();

    rob_ptr_ctrl #(
        .DEPTH          (DEPTH)
    ) u_ptr (
        .CLK            (CLK),
        .nRST           (nRST),
        .enqueue        (enq_valid),
        .retire         (head_bus.head_retire),
        .alloc          (alloc),
        .head_index     (head_index),
        .tail_index     (tail_index),
        .occupancy      (occupancy),
        .full           (full),
        .empty          (empty),
        .overflow_error (overflow_error)
    );

    rob_entry_array #(
        .DEPTH            (DEPTH)
    ) u_array (
        .CLK              (CLK),
        .nRST             (nRST),
        .alloc            (alloc),
        .tail_index       (tail_index),
        .head_index       (head_index),
        .enq_reg_write    (enq_reg_write),
        .enq_halt         (enq_halt),
        .enq_spec_tag     (enq_spec_tag),
        .enq_safe_tag     (enq_safe_tag),
        .comp_valid       (comp_valid),
        .comp_index       (comp_index),
        .comp_tag         (comp_tag),
        .head             (head_bus.store),
        .invalid_complete (invalid_complete),
        .tag_error        (tag_error)
    );

    rob_retire u_retire (
        .CLK          (CLK),
        .nRST         (nRST),
        .head         (head_bus.retire),
        .retire_valid (retire_valid),
        .retire_tag   (retire_tag),
        .halt         (halt)
    );

    // both strobes already registered
    assign error = overflow_error | tag_error;

endmodule

`default_nettype wire

//--- dv/rob_tb.sv
/* reorder buffer testbench
   per-cycle table of dispatch, completions and expected retire and status */
`timescale 1ns/1ns
`default_nettype none

module rob_tb;

    localparam int CLK_PERIOD = 8;
    localparam int MAX_ROWS   = 64;
    localparam int NB         = rob_pkg::NUM_COMPLETE;
    localparam logic [14:0] NO_ENQ  = '0;
    localparam logic [29:0] NO_COMP = '0;

    logic CLK;
    logic nRST;

    // dut inputs
    logic                           enq_valid;
    logic                           enq_reg_write;
    logic                           enq_halt;
    rob_pkg::phys_tag_t             enq_spec_tag;
    rob_pkg::phys_tag_t             enq_safe_tag;
    logic                [NB-1:0]   comp_valid;
    rob_pkg::rob_index_t [NB-1:0]   comp_index;
    rob_pkg::phys_tag_t  [NB-1:0]   comp_tag;

    // dut outputs
    rob_pkg::rob_index_t tail_index;
    logic                retire_valid;
    rob_pkg::phys_tag_t  retire_tag;
    logic                halt;
    logic                full;
    logic                empty;
    rob_pkg::rob_ptr_t   occupancy;
    logic                invalid_complete;
    logic                error;

    // stimulus table, one row per cycle
    string       row_name [MAX_ROWS];
    logic [14:0] row_enq  [MAX_ROWS];
    logic [29:0] row_comp [MAX_ROWS];
    logic [18:0] row_exp  [MAX_ROWS];
    int          num_rows;

    rob_top #(
        .DEPTH (8)
    ) u_dut (
        .CLK (CLK), .nRST (nRST),
        .enq_valid (enq_valid), .enq_reg_write (enq_reg_write), .enq_halt (enq_halt),
        .enq_spec_tag (enq_spec_tag), .enq_safe_tag (enq_safe_tag), .tail_index (tail_index),
        .comp_valid (comp_valid), .comp_index (comp_index), .comp_tag (comp_tag),
        .retire_valid (retire_valid), .retire_tag (retire_tag), .halt (halt),
        .full (full), .empty (empty), .occupancy (occupancy),
        .invalid_complete (invalid_complete), .error (error)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    //////////////////////////////////////////////////
    // row builders
    //////////////////////////////////////////////////

    // {valid, reg_write, halt, spec tag, safe tag}
    function automatic logic [14:0] enq_of(input int rw, input int hlt,
                                           input int spec, input int safe);
        return {1'b1, 1'(rw), 1'(hlt), 6'(spec), 6'(safe)};
    endfunction

    // ten bits per bus as {valid, index, tag}
    function automatic logic [29:0] comp_on(input int bus, input int idx, input int tag);
        logic [29:0] word;
        word = '0;
        word[bus*10 +: 10] = {1'b1, 3'(idx), 6'(tag)};
        return word;
    endfunction

    // {retire_valid, retire_tag, halt, full, empty, occupancy, invalid, error, tail}
    function automatic logic [18:0] exp_of(input int rv, input int rtag, input int hlt,
                                           input int fl, input int em, input int occ,
                                           input int inv, input int err, input int tl);
        return {1'(rv), 6'(rtag), 1'(hlt), 1'(fl), 1'(em), 4'(occ), 1'(inv), 1'(err),
                3'(tl)};
    endfunction

    task automatic add_row(input string name, input logic [14:0] enq,
                           input logic [29:0] comp, input logic [18:0] expected);
        row_name[num_rows] = name;
        row_enq[num_rows]  = enq;
        row_comp[num_rows] = comp;
        row_exp[num_rows]  = expected;
        num_rows++;
    endtask

    //////////////////////////////////////////////////
    // drive and check
    //////////////////////////////////////////////////

    task automatic compare(input string test_name, input string what,
                           input logic [7:0] expected, input logic [7:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s %s: expected %0h actual %0h",
                     test_name, what, expected, actual);
            $display("Checks failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic drive_row(input int r);
        logic [14:0] e;
        logic [29:0] c;
        e = row_enq[r];
        c = row_comp[r];
        enq_valid     = e[14];
        enq_reg_write = e[13];
        enq_halt      = e[12];
        enq_spec_tag  = e[11:6];
        enq_safe_tag  = e[5:0];
        for (int b = 0; b < NB; b++) begin
            comp_valid[b] = c[b*10+9];
            comp_index[b] = c[b*10+6 +: 3];
            comp_tag[b]   = c[b*10 +: 6];
        end
    endtask

    task automatic check_row(input int r);
        logic [18:0] x;
        x = row_exp[r];
        compare(row_name[r], "retire_valid", x[18], retire_valid);
        // tag only meaningful with a freed register
        if (x[18]) begin
            compare(row_name[r], "retire_tag", x[17:12], retire_tag);
        end
        compare(row_name[r], "halt", x[11], halt);
        compare(row_name[r], "full", x[10], full);
        compare(row_name[r], "empty", x[9], empty);
        compare(row_name[r], "occupancy", x[8:5], occupancy);
        compare(row_name[r], "invalid_complete", x[4], invalid_complete);
        compare(row_name[r], "error", x[3], error);
        compare(row_name[r], "tail_index", x[2:0], tail_index);
    endtask

    //////////////////////////////////////////////////
    // table
    //////////////////////////////////////////////////

    task automatic build_table();
        // four entries, completed 3, 1, 0, 2; entry 2 writes no register
        add_row("inorder", enq_of(1, 0, 'h10, 'h20), NO_COMP, exp_of(0, 0, 0, 0, 1, 0, 0, 0, 0));
        add_row("inorder", enq_of(1, 0, 'h11, 'h21), NO_COMP, exp_of(0, 0, 0, 0, 0, 1, 0, 0, 1));
        add_row("inorder", enq_of(0, 0, 'h12, 'h22), NO_COMP, exp_of(0, 0, 0, 0, 0, 2, 0, 0, 2));
        add_row("inorder", enq_of(1, 0, 'h13, 'h23), NO_COMP, exp_of(0, 0, 0, 0, 0, 3, 0, 0, 3));
        add_row("inorder", NO_ENQ, comp_on(0, 3, 'h13), exp_of(0, 0, 0, 0, 0, 4, 0, 0, 4));
        add_row("inorder", NO_ENQ, comp_on(1, 1, 'h11), exp_of(0, 0, 0, 0, 0, 4, 0, 0, 4));
        add_row("inorder", NO_ENQ, comp_on(2, 0, 'h10), exp_of(0, 0, 0, 0, 0, 4, 0, 0, 4));
        add_row("inorder", NO_ENQ, comp_on(0, 2, 'h12), exp_of(1, 'h20, 0, 0, 0, 4, 0, 0, 4));
        add_row("inorder", NO_ENQ, NO_COMP, exp_of(1, 'h21, 0, 0, 0, 3, 0, 0, 4));
        add_row("inorder", NO_ENQ, NO_COMP, exp_of(0, 0, 0, 0, 0, 2, 0, 0, 4));
        add_row("inorder", NO_ENQ, NO_COMP, exp_of(1, 'h23, 0, 0, 0, 1, 0, 0, 4));
        add_row("inorder", NO_ENQ, NO_COMP, exp_of(0, 0, 0, 0, 1, 0, 0, 0, 4));
        // eight entries from slot 4, then a refused ninth
        for (int j = 0; j < 8; j++) begin
            add_row("full", enq_of(1, 0, 'h30 + j, 'h38 + j), NO_COMP,
                    exp_of(0, 0, 0, 0, (j == 0), j, 0, 0, (4 + j) % 8));
        end
        add_row("full", enq_of(1, 0, 'h00, 'h00), NO_COMP, exp_of(0, 0, 0, 1, 0, 8, 0, 0, 4));
        add_row("full", NO_ENQ, comp_on(0, 4, 'h30) | comp_on(1, 5, 'h31) | comp_on(2, 6, 'h32),
                exp_of(0, 0, 0, 1, 0, 8, 0, 1, 4));
        add_row("full", NO_ENQ, comp_on(0, 7, 'h33) | comp_on(1, 0, 'h34) | comp_on(2, 1, 'h35),
                exp_of(1, 'h38, 0, 1, 0, 8, 0, 0, 4));
        add_row("full", NO_ENQ, comp_on(0, 2, 'h36) | comp_on(1, 3, 'h37),
                exp_of(1, 'h39, 0, 0, 0, 7, 0, 0, 4));
        for (int j = 2; j < 8; j++) begin
            add_row("full", NO_ENQ, NO_COMP, exp_of(1, 'h38 + j, 0, 0, 0, 8 - j, 0, 0, 4));
        end
        add_row("full", NO_ENQ, NO_COMP, exp_of(0, 0, 0, 0, 1, 0, 0, 0, 4));
        // slots 4..6 finish together on crossed buses
        add_row("simul", enq_of(1, 0, 'h01, 'h04), NO_COMP, exp_of(0, 0, 0, 0, 1, 0, 0, 0, 4));
        add_row("simul", enq_of(1, 0, 'h02, 'h05), NO_COMP, exp_of(0, 0, 0, 0, 0, 1, 0, 0, 5));
        add_row("simul", enq_of(1, 0, 'h03, 'h06), NO_COMP, exp_of(0, 0, 0, 0, 0, 2, 0, 0, 6));
        add_row("simul", NO_ENQ, comp_on(0, 6, 'h03) | comp_on(1, 4, 'h01) | comp_on(2, 5, 'h02),
                exp_of(0, 0, 0, 0, 0, 3, 0, 0, 7));
        add_row("simul", NO_ENQ, NO_COMP, exp_of(1, 'h04, 0, 0, 0, 3, 0, 0, 7));
        add_row("simul", NO_ENQ, NO_COMP, exp_of(1, 'h05, 0, 0, 0, 2, 0, 0, 7));
        add_row("simul", NO_ENQ, NO_COMP, exp_of(1, 'h06, 0, 0, 0, 1, 0, 0, 7));
        add_row("simul", NO_ENQ, NO_COMP, exp_of(0, 0, 0, 0, 1, 0, 0, 0, 7));
        // wrong tag on slot 7 still completes it
        add_row("tag", enq_of(1, 0, 'h2a, 'h15), NO_COMP, exp_of(0, 0, 0, 0, 1, 0, 0, 0, 7));
        add_row("tag", NO_ENQ, comp_on(1, 7, 'h2b), exp_of(0, 0, 0, 0, 0, 1, 0, 0, 0));
        add_row("tag", NO_ENQ, NO_COMP, exp_of(1, 'h15, 0, 0, 0, 1, 0, 1, 0));
        add_row("tag", NO_ENQ, NO_COMP, exp_of(0, 0, 0, 0, 1, 0, 0, 0, 0));
        // empty buffer, slot 3 holds nothing
        add_row("invalid", NO_ENQ, comp_on(2, 3, 'h07), exp_of(0, 0, 0, 0, 1, 0, 1, 0, 0));
        add_row("invalid", NO_ENQ, NO_COMP, exp_of(0, 0, 0, 0, 1, 0, 0, 0, 0));
        // halt at slot 0, normal op at slot 1, each completed as it enqueues
        add_row("halt", enq_of(0, 1, 'h09, 'h0a), comp_on(0, 0, 'h09),
                exp_of(0, 0, 0, 0, 1, 0, 0, 0, 0));
        add_row("halt", enq_of(1, 0, 'h0b, 'h0c), comp_on(1, 1, 'h0b),
                exp_of(0, 0, 0, 0, 0, 1, 0, 0, 1));
        for (int j = 0; j < 3; j++) begin
            add_row("halt", NO_ENQ, NO_COMP, exp_of(0, 0, 1, 0, 0, 1, 0, 0, 2));
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        nRST          = 1'b0;
        num_rows      = 0;
        enq_valid     = 1'b0;
        enq_reg_write = 1'b0;
        enq_halt      = 1'b0;
        enq_spec_tag  = '0;
        enq_safe_tag  = '0;
        comp_valid    = '0;
        comp_index    = '0;
        comp_tag      = '0;
        build_table();
        repeat (8) @(posedge CLK);
        #1;
        nRST = 1'b1;
        for (int r = 0; r < num_rows; r++) begin
            drive_row(r);
            // sample just before the next edge
            #(CLK_PERIOD - 2);
            check_row(r);
            @(posedge CLK);
            #1;
        end
        $display("All checks passed");
        $finish;
    end

    initial begin
        #1;
        #((num_rows + 20) * CLK_PERIOD);
        $display("Checks failed");
        $fatal(1, "watchdog expired before the table finished");
    end

endmodule

`default_nettype wire

//--- list.f
verilog/rob_pkg.sv
verilog/rob_head_if.sv
verilog/rob_ptr_ctrl.sv
verilog/rob_entry_array.sv
verilog/rob_retire.sv
verilog/rob_top.sv
dv/rob_tb.sv
